// File: gnn_dispatch.f
+incdir+common
common/gnn_dispatch_pkg.sv
hdl/cmd_fifo.sv
decoder/cmd_decoder.sv
hdl/task_queue.sv
hdl/gnn_dispatch_top.sv
verif/tb_gnn_dispatch.sv

// File: Makefile
SIM        = verilator
TOP        = tb_gnn_dispatch
FILELIST   = gnn_dispatch.f
FLAGS      = --binary --timing -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
OBJ_DIR    = obj_dir
PASS_MSG   = Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: verif/tb_gnn_dispatch.sv
`timescale 1ns/100ps
`include "gnn_dispatch_macros.svh"

module tb_gnn_dispatch;
    import gnn_dispatch_pkg::*;

    localparam int NUM_CMDS   = 60;
    localparam int MAX_WAIT   = 40;                   // longest random wait of one command
    localparam int MAX_CYCLES = NUM_CMDS * MAX_WAIT + 100;
    localparam replay_iter_t LAST_ITER = replay_iter_t'(`MAX_REPLAY_ITER - 1);

    logic clk, reset, cmd_wr, cmd_full, task_take, mem_req, grant;
    logic bank_busy, stream_end, vertex_done, cntl_done, task_complete;
    cmd_word_t     cmd_data;
    rs_task_t      task_out;
    mem_pkt_t      mem_out;
    pe_mask_t      pe_idle;
    replay_iter_t  replay_iter;
    num_fv_t       num_fv;
    weight_bound_t weight_bound;

    integer        seed = 32'h4a81;
    rs_task_t      exp_task[$];
    int            exp_task_mem[$];                   // mem packets that must come before the task
    mem_pkt_t      exp_mem[$];
    replay_iter_t  model_iter;
    num_fv_t       model_fv;
    weight_bound_t model_wb;
    int mem_total, mem_count, cntl_count, done_count, exp_cntl, exp_done;
    int pass_count, err_count, task_index, cycles;

    gnn_dispatch_top u_gnn_dispatch_top (
        .clk (clk), .reset (reset), .cmd_wr (cmd_wr), .cmd_data (cmd_data),
        .cmd_full (cmd_full), .task_out (task_out), .task_take (task_take),
        .mem_req (mem_req), .grant (grant), .mem_out (mem_out), .bank_busy (bank_busy),
        .pe_idle (pe_idle), .stream_end (stream_end), .vertex_done (vertex_done),
        .cntl_done (cntl_done), .task_complete (task_complete), .replay_iter (replay_iter),
        .num_fv (num_fv), .weight_bound (weight_bound)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    function automatic int rand_between(input int lo, input int hi);
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return lo + r % (hi - lo + 1);
    endfunction

    task automatic tally(input bit ok, input string name, input string exp, input string act);
        if (ok) begin
            pass_count++;
            $display("ok %s %s", name, act);
        end else begin
            err_count++;
            $display("Error %s expected %s actual %s", name, exp, act);
        end
    endtask

    task automatic report_problem(input string msg);
        err_count++;
        $display("%s", msg);
    endtask

    task automatic check_task(input string name, input rs_task_t exp, input rs_task_t act);
        tally(act === exp, name, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic check_mem(input string name, input mem_pkt_t exp, input mem_pkt_t act);
        tally(act === exp, name, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic check_iter(input string name, input replay_iter_t exp, input replay_iter_t act);
        tally(act === exp, name, $sformatf("%0d", exp), $sformatf("%0d", act));
    endtask

    task automatic check_cfg(input string name, input num_fv_t exp_fv, input weight_bound_t exp_wb,
                             input num_fv_t act_fv, input weight_bound_t act_wb);
        tally(act_fv === exp_fv && act_wb === exp_wb, name,
              $sformatf("fv=%h wb=%h", exp_fv, exp_wb), $sformatf("fv=%h wb=%h", act_fv, act_wb));
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        tally(act === exp, name, $sformatf("%b", exp), $sformatf("%b", act));
    endtask

    // every call starts and ends 2 ns after a rising edge
    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic write_cmd(input cmd_word_t word);
        while (cmd_full)
            step(1);
        cmd_wr   = 1'b1;
        cmd_data = word;
        step(1);
        cmd_wr   = 1'b0;
    endtask

    task automatic issue_task(input cmd_word_t word);
        while (exp_task.size() >= 6)                   // keeps the task queue from overflowing
            step(1);
        exp_task.push_back(rs_task_t'({1'b1, word[`CMD_WIDTH-3:0]}));
        exp_task_mem.push_back(mem_total);
        write_cmd(word);
    endtask

    task automatic run_fetch(input cmd_word_t word);
        cmd_word_t follow;
        exp_mem.push_back(mem_pkt_t'({1'b1, word}));
        mem_total++;
        write_cmd(word);
        follow = {2'b00, task_word_t'($random(seed))};
        follow[10 + model_iter] = 1'b1;                // waits in the FIFO behind the fetch
        issue_task(follow);
        @(negedge clk);
        while (!mem_req)
            @(negedge clk);
        step(1);
        repeat (rand_between(0, 6)) step(1);
        grant = 1'b1;
        @(negedge clk);
        if (mem_req)
            report_problem("mem_req still high in the grant cycle");
        if (!mem_out.valid)
            report_problem("no mem_out strobe in the grant cycle");
        step(1);
        grant = 1'b0;
    endtask

    task automatic run_replay(input cmd_word_t word);
        bit last;
        int mem_before, cntl_before;
        last        = (model_iter == LAST_ITER);
        mem_before  = mem_count;
        cntl_before = cntl_count;
        if (!last) begin
            exp_mem.push_back(mem_pkt_t'({1'b1, word}));
            mem_total++;
        end
        bank_busy = 1'b1;
        write_cmd(word);
        repeat (rand_between(2, 7)) begin
            bank_busy = 1'($random(seed));
            pe_idle   = pe_mask_t'($random(seed));
            step(1);
        end
        bank_busy = 1'b0;
        pe_idle   = '1;
        if (!last) begin
            while (mem_count == mem_before)
                @(negedge clk);
            step(1);
            model_iter = replay_iter_t'(model_iter + 1);
            repeat (rand_between(0, 4)) step(1);
            stream_end = 1'b1;
            step(1);
            stream_end = 1'b0;
        end else begin
            exp_cntl++;
            exp_done++;
            while (cntl_count == cntl_before)
                @(negedge clk);
            step(1);
            repeat (rand_between(0, 4)) step(1);
            vertex_done = 1'b1;
            @(negedge clk);
            if (!task_complete)
                report_problem("task_complete did not pulse with vertex_done");
            step(1);
            vertex_done = 1'b0;
            model_iter  = '0;
        end
        @(negedge clk);
        check_iter($sformatf("replay iter %0d", cntl_count), model_iter, replay_iter);
        step(1);
    endtask

    task automatic run_weight(input cmd_word_t word);
        cmd_word_t fv_word;
        num_fv_t   old_fv;
        old_fv   = model_fv;
        model_wb = word[$bits(weight_bound_t)-1:0];
        write_cmd(word);
        // the held stream fills the command FIFO to the brim
        repeat (`CMD_FIFO_DEPTH) begin
            fv_word = {2'b10, task_word_t'($random(seed))};
            if (fv_word[$bits(num_fv_t)-1:0] == old_fv)
                fv_word[0] = ~fv_word[0];              // a visible change proves the hold
            write_cmd(fv_word);
        end
        repeat (rand_between(3, 8)) step(1);
        @(negedge clk);
        check_flag("cmd_full while held", 1'b1, cmd_full);
        check_cfg("weight hold", old_fv, model_wb, num_fv, weight_bound);
        step(1);
        stream_end = 1'b1;
        step(1);
        stream_end = 1'b0;
        step(`CMD_FIFO_DEPTH);
        @(negedge clk);
        model_fv = fv_word[$bits(num_fv_t)-1:0];
        check_flag("cmd_full after drain", 1'b0, cmd_full);
        check_cfg("weight release", model_fv, model_wb, num_fv, weight_bound);
        step(1);
    endtask

    task automatic run_command();
        cmd_word_t word;
        word = cmd_word_t'($random(seed));
        case (cmd_op_t'(word[`CMD_WIDTH-1 -: 2]))
            op_task: begin
                if (word[10 + model_iter])
                    issue_task(word);
                else
                    run_fetch(word);
            end
            op_replay: run_replay(word);
            op_num_fv: begin
                model_fv = word[$bits(num_fv_t)-1:0];
                write_cmd(word);
                step(2);
                @(negedge clk);
                check_cfg("num_fv", model_fv, model_wb, num_fv, weight_bound);
                step(1);
            end
            default: run_weight(word);
        endcase
    endtask

    // random pops toward the PEs, judged against the expected task order
    initial begin
        task_take = 1'b0;
        forever begin
            step(1);
            task_take = 1'($random(seed));
            @(negedge clk);
            if (task_take && task_out.valid) begin
                if (exp_task.size() == 0) begin
                    report_problem("task_out held a task that was never issued");
                end else begin
                    if (mem_count < exp_task_mem[0])
                        report_problem("task passed a fetch that was not yet granted");
                    check_task($sformatf("task %0d", task_index), exp_task.pop_front(), task_out);
                    void'(exp_task_mem.pop_front());
                    task_index++;
                end
            end
        end
    end

    always @(negedge clk) begin
        if (!reset) begin
            if (mem_out.valid) begin
                if (exp_mem.size() == 0) begin
                    report_problem("mem_out strobed with no packet expected");
                end else begin
                    if (mem_out.word[`CMD_WIDTH-1 -: 2] == op_replay &&
                        (bank_busy || !(&pe_idle) || task_out.valid))
                        report_problem("replay marker sent while banks, PEs or tasks were busy");
                    check_mem($sformatf("mem %0d", mem_count), exp_mem.pop_front(), mem_out);
                end
                mem_count++;
            end
            if (cntl_done)
                cntl_count++;
            if (task_complete)
                done_count++;
        end
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run was still busy after %0d cycles", MAX_CYCLES);
        $display("Verification failed");
        $finish;
    end

    initial begin
        reset       = 1'b1;
        cmd_wr      = 1'b0;
        cmd_data    = '0;
        grant       = 1'b0;
        bank_busy   = 1'b0;
        pe_idle     = '1;
        stream_end  = 1'b0;
        vertex_done = 1'b0;
        model_iter  = '0;
        model_fv    = '0;
        model_wb    = '0;
        step(2);
        reset = 1'b0;
        @(negedge clk);
        check_iter("reset iter", '0, replay_iter);
        check_cfg("reset cfg", '0, '0, num_fv, weight_bound);
        check_flag("reset cmd_full", 1'b0, cmd_full);
        step(1);
        for (int i = 0; i < NUM_CMDS; i++)
            run_command();
        while (exp_task.size() != 0)
            step(1);
        step(4);
        if (exp_mem.size() != 0)
            report_problem($sformatf("%0d memory packets never appeared", exp_mem.size()));
        if (cntl_count != exp_cntl)
            report_problem($sformatf("cntl_done pulsed %0d times, %0d due", cntl_count, exp_cntl));
        if (done_count != exp_done)
            report_problem($sformatf("task_complete pulsed %0d times, %0d due",
                                     done_count, exp_done));
        $display("Tests: %0d passed, %0d failed", pass_count, err_count);
        if (err_count == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// File: hdl/gnn_dispatch_top.sv
`timescale 1ns/100ps

module gnn_dispatch_top (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            cmd_wr,
    input  gnn_dispatch_pkg::cmd_word_t     cmd_data,
    output logic                            cmd_full,
    output gnn_dispatch_pkg::rs_task_t      task_out,
    input  logic                            task_take,
    output logic                            mem_req,
    input  logic                            grant,
    output gnn_dispatch_pkg::mem_pkt_t      mem_out,
    input  logic                            bank_busy,
    input  gnn_dispatch_pkg::pe_mask_t      pe_idle,
    input  logic                            stream_end,
    input  logic                            vertex_done,
    output logic                            cntl_done,
    output logic                            task_complete,
    output gnn_dispatch_pkg::replay_iter_t  replay_iter,
    output gnn_dispatch_pkg::num_fv_t       num_fv,
    output gnn_dispatch_pkg::weight_bound_t weight_bound
);
    import gnn_dispatch_pkg::*;

    cmd_pkt_t cmd_head;
    rs_task_t rs_task;
    logic     fifo_stall;
    logic     rs_empty;

    cmd_fifo u_cmd_fifo (
        .clk        (clk),
        .reset      (reset),
        .cmd_wr     (cmd_wr),
        .cmd_data   (cmd_data),
        .fifo_stall (fifo_stall),
        .cmd_full   (cmd_full),
        .cmd_head   (cmd_head)
    );

    cmd_decoder u_cmd_decoder (
        .clk           (clk),
        .reset         (reset),
        .cmd_head      (cmd_head),
        .rs_empty      (rs_empty),
        .grant         (grant),
        .bank_busy     (bank_busy),
        .pe_idle       (pe_idle),
        .stream_end    (stream_end),
        .vertex_done   (vertex_done),
        .fifo_stall    (fifo_stall),
        .rs_task       (rs_task),
        .mem_req       (mem_req),
        .mem_out       (mem_out),
        .cntl_done     (cntl_done),
        .task_complete (task_complete),
        .replay_iter   (replay_iter),
        .num_fv        (num_fv),
        .weight_bound  (weight_bound)
    );

    // queue emptiness closes the decoder's replay condition
    task_queue u_task_queue (
        .clk       (clk),
        .reset     (reset),
        .rs_task   (rs_task),
        .task_take (task_take),
        .task_out  (task_out),
        .rs_empty  (rs_empty)
    );

endmodule

// File: hdl/task_queue.sv
`timescale 1ns/100ps
`include "gnn_dispatch_macros.svh"

module task_queue (
    input  logic                       clk,
    input  logic                       reset,
    input  gnn_dispatch_pkg::rs_task_t rs_task,
    input  logic                       task_take,
    output gnn_dispatch_pkg::rs_task_t task_out,
    output logic                       rs_empty
);
    import gnn_dispatch_pkg::*;

    localparam int DEPTH = `TASK_Q_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    task_word_t       mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             full;
    logic             push;
    logic             pop;

    assign rs_empty = (count == '0);
    assign full     = (count == (PTR_W+1)'(DEPTH));

    // replay markers wait for an empty queue, so a full push should not happen
    assign push = rs_task.valid && !full;
    assign pop  = task_take && !rs_empty;

    // show-ahead head toward the PEs
    assign task_out.valid   = !rs_empty;
    assign task_out.payload = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= rs_task.payload;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;                   // idle, or push and pop together
                end
            endcase
        end
    end

endmodule

// File: decoder/cmd_decoder.sv
`timescale 1ns/100ps
`include "gnn_dispatch_macros.svh"

module cmd_decoder (
    input  logic                            clk,
    input  logic                            reset,
    input  gnn_dispatch_pkg::cmd_pkt_t      cmd_head,
    input  logic                            rs_empty,
    input  logic                            grant,
    input  logic                            bank_busy,
    input  gnn_dispatch_pkg::pe_mask_t      pe_idle,
    input  logic                            stream_end,
    input  logic                            vertex_done,
    output logic                            fifo_stall,
    output gnn_dispatch_pkg::rs_task_t      rs_task,
    output logic                            mem_req,
    output gnn_dispatch_pkg::mem_pkt_t      mem_out,
    output logic                            cntl_done,
    output logic                            task_complete,
    output gnn_dispatch_pkg::replay_iter_t  replay_iter,
    output gnn_dispatch_pkg::num_fv_t       num_fv,
    output gnn_dispatch_pkg::weight_bound_t weight_bound
);
    import gnn_dispatch_pkg::*;

    localparam replay_iter_t LAST_ITER = replay_iter_t'(`MAX_REPLAY_ITER - 1);

    dec_state_t    state;
    dec_state_t    nx_state;
    cmd_word_t     pending;                    // command held while it waits for memory
    cmd_word_t     nx_pending;
    replay_iter_t  replay_iter_q;
    replay_iter_t  nx_replay_iter;
    num_fv_t       num_fv_q;
    num_fv_t       nx_num_fv;
    weight_bound_t weight_bound_q;
    weight_bound_t nx_weight_bound;
    logic          req_q;
    logic          nx_req;
    logic          nx_fifo_stall;
    logic          replay_ready;
    cmd_op_t       op;
    logic [`MAX_REPLAY_ITER-1:0] iter_mask;

    assign op        = cmd_op_t'(cmd_head.word[`CMD_WIDTH-1 -: 2]);
    assign iter_mask = cmd_head.word[`CMD_WIDTH-3 -: `MAX_REPLAY_ITER];

    // the next pass may start only once every consumer of the last one has drained
    assign replay_ready = !bank_busy && rs_empty && (&pe_idle);

    assign replay_iter  = replay_iter_q;
    assign num_fv       = num_fv_q;
    assign weight_bound = weight_bound_q;
    assign mem_req      = nx_req;              // up in the decode cycle, down in the grant cycle

    always_ff @(posedge clk) begin
        pending <= nx_pending;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state          <= st_idle;
            replay_iter_q  <= '0;
            num_fv_q       <= '0;
            weight_bound_q <= '0;
            req_q          <= 1'b0;
            fifo_stall     <= 1'b0;
        end else begin
            state          <= nx_state;
            replay_iter_q  <= nx_replay_iter;
            num_fv_q       <= nx_num_fv;
            weight_bound_q <= nx_weight_bound;
            req_q          <= nx_req;
            fifo_stall     <= nx_fifo_stall;
        end
    end

    always_comb begin
        nx_state        = state;
        nx_pending      = pending;
        nx_replay_iter  = replay_iter_q;
        nx_num_fv       = num_fv_q;
        nx_weight_bound = weight_bound_q;
        nx_req          = req_q;
        nx_fifo_stall   = 1'b0;
        rs_task         = '0;
        mem_out         = '0;
        cntl_done       = 1'b0;
        task_complete   = 1'b0;

        case (state)
            st_idle: begin
                if (cmd_head.valid) begin
                    case (op)
                        op_task: begin
                            if (iter_mask[replay_iter_q]) begin
                                rs_task.valid   = 1'b1;
                                rs_task.payload = cmd_head.word[`CMD_WIDTH-3:0];
                            end else begin
                                nx_req        = 1'b1;  // not enabled this pass, fetch instead
                                nx_pending    = cmd_head.word;
                                nx_fifo_stall = 1'b1;
                                nx_state      = st_wait_grant;
                            end
                        end
                        op_replay: begin
                            nx_pending     = cmd_head.word;
                            nx_fifo_stall  = 1'b1;
                            nx_state       = st_wait_replay;
                        end
                        op_num_fv: begin
                            nx_num_fv = cmd_head.word[$bits(num_fv_t)-1:0];
                        end
                        op_weight: begin
                            nx_weight_bound = cmd_head.word[$bits(weight_bound_t)-1:0];
                            nx_fifo_stall   = 1'b1;
                            nx_state        = st_wait_stream;
                        end
                    endcase
                end
            end
            st_wait_grant: begin
                if (grant) begin
                    mem_out.valid = 1'b1;
                    mem_out.word  = pending;
                    nx_req        = 1'b0;
                    nx_state      = st_idle;
                end else begin
                    nx_fifo_stall = 1'b1;
                end
            end
            st_wait_replay: begin
                nx_fifo_stall = 1'b1;
                if (replay_ready) begin
                    if (replay_iter_q == LAST_ITER) begin
                        cntl_done = 1'b1;              // last pass, no marker goes to memory
                        nx_state  = st_wait_vertex;
                    end else begin
                        mem_out.valid  = 1'b1;
                        mem_out.word   = pending;
                        nx_replay_iter = replay_iter_q + 1'b1;
                        nx_state       = st_wait_stream;
                    end
                end
            end
            st_wait_stream: begin
                if (stream_end) begin
                    nx_state       = st_idle;
                end else begin
                    nx_fifo_stall = 1'b1;
                end
            end
            st_wait_vertex: begin
                if (vertex_done) begin
                    task_complete  = 1'b1;
                    nx_replay_iter = '0;
                    nx_state       = st_idle;
                end else begin
                    nx_fifo_stall = 1'b1;
                end
            end
            default: begin
                nx_req   = 1'b0;
                nx_state = st_idle;
            end
        endcase
    end

endmodule

// File: hdl/cmd_fifo.sv
`timescale 1ns/100ps
`include "gnn_dispatch_macros.svh"

module cmd_fifo (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        cmd_wr,
    input  gnn_dispatch_pkg::cmd_word_t cmd_data,
    input  logic                        fifo_stall,
    output logic                        cmd_full,
    output gnn_dispatch_pkg::cmd_pkt_t  cmd_head
);
    import gnn_dispatch_pkg::*;

    localparam int DEPTH = `CMD_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    cmd_word_t        mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             push;
    logic             pop;
    logic             empty;

    assign empty    = (count == '0);
    assign cmd_full = (count == (PTR_W+1)'(DEPTH));

    // writes into a full FIFO are dropped
    assign push = cmd_wr && !cmd_full;

    // the decoder takes every presented word, so presenting it is the pop
    assign pop = !empty && !fifo_stall;

    assign cmd_head.valid = pop;
    assign cmd_head.word  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= cmd_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;          // depth is a power of two, pointer wraps
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

endmodule

// File: common/gnn_dispatch_pkg.sv
`include "gnn_dispatch_macros.svh"

package gnn_dispatch_pkg;

    typedef logic [`CMD_WIDTH-1:0] cmd_word_t;        // opcode in 15:14, iteration mask in 13:10
    typedef logic [`CMD_WIDTH-3:0] task_word_t;       // task payload without the opcode
    typedef logic [$clog2(`MAX_REPLAY_ITER)-1:0] replay_iter_t;
    typedef logic [4:0] num_fv_t;
    typedef logic [3:0] weight_bound_t;
    typedef logic [`NUM_EDGE_PE-1:0] pe_mask_t;       // one idle bit per edge PE

    typedef enum logic [1:0] {
        op_task   = 2'b00,
        op_replay = 2'b01,
        op_num_fv = 2'b10,
        op_weight = 2'b11
    } cmd_op_t;

    typedef enum logic [2:0] {
        st_idle        = 3'd0,
        st_wait_grant  = 3'd1,
        st_wait_replay = 3'd2,
        st_wait_stream = 3'd3,
        st_wait_vertex = 3'd4
    } dec_state_t;

    // head word of the command FIFO toward the decoder
    typedef struct packed {
        logic      valid;
        cmd_word_t word;
    } cmd_pkt_t;

    // task issued to the reservation station
    typedef struct packed {
        logic       valid;
        task_word_t payload;
    } rs_task_t;

    // fetch or replay packet toward the memory banks
    typedef struct packed {
        logic      valid;
        cmd_word_t word;
    } mem_pkt_t;

endpackage

// File: common/gnn_dispatch_macros.svh
`ifndef GNN_DISPATCH_MACROS_SVH
`define GNN_DISPATCH_MACROS_SVH

// host command word, opcode in the top two bits
`define CMD_WIDTH 16

// replay passes over one vertex batch
`define MAX_REPLAY_ITER 4

`define NUM_EDGE_PE 4

// entries in the issued task queue
`define TASK_Q_DEPTH 8

// entries in the host command FIFO
`define CMD_FIFO_DEPTH 8

`endif
